// ==== hdl/hub75_pkg.sv ====
// ----------------------------
// shared types and constants for the hub75 panel driver
// import into any block that needs panel geometry or port structs
// ----------------------------
`default_nettype none

package hub75_pkg;

  // panel geometry, 64 x 64 scanned as 32 row pairs
  localparam int panel_columns = 64;
  localparam int scan_lines = 32;

  // phase lengths counted in scan ticks
  localparam int latch_ticks = 2;
  localparam int show_ticks = 32;

  // clk cycles per scan tick unless the top level overrides it
  localparam int default_div_ratio = 16;

  typedef logic [$clog2(panel_columns)-1:0] column_t;
  typedef logic [$clog2(scan_lines)-1:0] row_t;

  // one pixel, red sits in bit 0 to match the connector order
  typedef struct packed {
    logic blue;
    logic green;
    logic red;
  } rgb_t;

  // host write into the frame buffer
  // half selects the panel half: 0 top, 1 bottom
  typedef struct packed {
    logic half;
    row_t row;
    column_t column;
    rgb_t color;
  } pixel_write_t;

  // everything that goes out on the hub75 connector
  typedef struct packed {
    row_t addr;
    logic oe_n;
    logic latch;
    logic sclk;
    rgb_t rgb_top;
    rgb_t rgb_bottom;
  } hub75_port_t;

endpackage

`default_nettype wire

// ==== hdl/scan_tick.sv ====
// ----------------------------
// scan tick generator
// gives a one clk enable pulse every div_ratio clocks
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module scan_tick #(
  parameter int div_ratio = hub75_pkg::default_div_ratio
) (
  input logic clk,
  input logic reset,
  output logic tick
);

  localparam int count_width = (div_ratio > 2) ? $clog2(div_ratio) : 1;
  localparam logic [count_width-1:0] last_count = count_width'(div_ratio - 1);

  // free running wrap counter, restarted by reset
  logic [count_width-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (count == last_count) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // enable is high during the last count of each period
  // so the first one lands div_ratio clocks after reset drops
  assign tick = (count == last_count);

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
// ----------------------------
// two-half pixel memory between the host and the scanner
// host writes single pixels, scanner reads one row pair per column
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input logic clk,
  input logic pixel_wr_en,
  input hub75_pkg::pixel_write_t pixel_wr,
  input hub75_pkg::row_t row,
  input hub75_pkg::column_t column,
  output hub75_pkg::rgb_t rgb_top,
  output hub75_pkg::rgb_t rgb_bottom
);

  import hub75_pkg::*;

  localparam int half_depth = scan_lines * panel_columns;
  localparam int index_width = $clog2(half_depth);

  // one array per panel half, 2048 pixels each
  rgb_t mem_top [half_depth];
  rgb_t mem_bottom [half_depth];

  logic [index_width-1:0] wr_index;
  logic [index_width-1:0] rd_index;

  // row in the upper bits, column in the lower bits
  assign wr_index = {pixel_wr.row, pixel_wr.column};
  assign rd_index = {row, column};

  // write port, half bit steers the pixel
  always_ff @(posedge clk) begin
    if (pixel_wr_en && !pixel_wr.half) begin
      mem_top[wr_index] <= pixel_wr.color;
    end
  end

  always_ff @(posedge clk) begin
    if (pixel_wr_en && pixel_wr.half) begin
      mem_bottom[wr_index] <= pixel_wr.color;
    end
  end

  // read port
  // both halves at the same index, data one clk after the address
  // a write on the same edge shows up on the next read
  always_ff @(posedge clk) begin
    rgb_top <= mem_top[rd_index];
    rgb_bottom <= mem_bottom[rd_index];
  end

endmodule

`default_nettype wire

// ==== hdl/line_scanner.sv ====
// ----------------------------
// hub75 line scanner FSM
// per row pair: shift 64 pixels, latch, show, advance address
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module line_scanner (
  input logic clk,
  input logic reset,
  input logic tick,
  output hub75_pkg::row_t row,
  output hub75_pkg::column_t column,
  output logic sclk,
  output logic latch,
  output logic oe_n
);

  import hub75_pkg::*;

  typedef enum logic [1:0] {
    state_shift,
    state_latch,
    state_show,
    state_advance
  } state_t;

  localparam int phase_width = $clog2(show_ticks);
  localparam column_t last_column = column_t'(panel_columns - 1);
  localparam logic [phase_width-1:0] last_latch = phase_width'(latch_ticks - 1);
  localparam logic [phase_width-1:0] last_show = phase_width'(show_ticks - 1);

  state_t state;

  // ticks spent in the latch or show phase
  logic [phase_width-1:0] show_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_shift;
      row <= '0;
      column <= '0;
      sclk <= 1'b0;
      latch <= 1'b0;
      oe_n <= 1'b1;
      show_count <= '0;
    end else if (tick) begin
      case (state)
        // two ticks per pixel
        // rising sclk clocks the pixel into the panel
        // column moves on the falling edge so the memory has a tick to catch up
        state_shift: begin
          sclk <= ~sclk;
          if (sclk) begin
            if (column == last_column) begin
              state <= state_latch;
              show_count <= '0;
            end else begin
              column <= column + 1'b1;
            end
          end
        end

        // latch high for one tick, then drop it together with oe_n
        state_latch: begin
          if (show_count == last_latch) begin
            latch <= 1'b0;
            oe_n <= 1'b0;
            show_count <= '0;
            state <= state_show;
          end else begin
            latch <= 1'b1;
            show_count <= show_count + 1'b1;
          end
        end

        // fixed display time, this sets the brightness
        state_show: begin
          if (show_count == last_show) begin
            oe_n <= 1'b1;
            show_count <= '0;
            state <= state_advance;
          end else begin
            show_count <= show_count + 1'b1;
          end
        end

        // output is dark here, safe to move the address
        // row wraps from 31 to 0 by width
        state_advance: begin
          row <= row + 1'b1;
          column <= '0;
          state <= state_shift;
        end

        default: begin
          state <= state_shift;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hub75_driver.sv ====
// ----------------------------
// hub75 panel driver top level
// host loads pixels, panel struct goes to the connector
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module hub75_driver #(
  parameter int div_ratio = hub75_pkg::default_div_ratio
) (
  input logic clk,
  input logic reset,
  input logic pixel_wr_en,
  input hub75_pkg::pixel_write_t pixel_wr,
  output hub75_pkg::hub75_port_t panel
);

  import hub75_pkg::*;

  logic tick;
  row_t row;
  column_t column;
  logic sclk;
  logic latch;
  logic oe_n;
  rgb_t rgb_top;
  rgb_t rgb_bottom;

  // clock enable for the scanner, whole design stays on clk
  scan_tick #(
    .div_ratio(div_ratio)
  ) i_scan_tick (
    .clk(clk),
    .reset(reset),
    .tick(tick)
  );

  // image memory, addressed by the scanner position
  frame_buffer i_frame_buffer (
    .clk(clk),
    .pixel_wr_en(pixel_wr_en),
    .pixel_wr(pixel_wr),
    .row(row),
    .column(column),
    .rgb_top(rgb_top),
    .rgb_bottom(rgb_bottom)
  );

  line_scanner i_line_scanner (
    .clk(clk),
    .reset(reset),
    .tick(tick),
    .row(row),
    .column(column),
    .sclk(sclk),
    .latch(latch),
    .oe_n(oe_n)
  );

  // scanner row doubles as the panel address
  assign panel.addr = row;
  assign panel.oe_n = oe_n;
  assign panel.latch = latch;
  assign panel.sclk = sclk;
  assign panel.rgb_top = rgb_top;
  assign panel.rgb_bottom = rgb_bottom;

endmodule

`default_nettype wire

// ==== bench/hub75_assertions.sv ====
// ----------------------------
// protocol checks on the scanner outputs
// bound into every line_scanner instance
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module hub75_assertions (
  input logic clk,
  input logic reset,
  input hub75_pkg::row_t row,
  input logic sclk,
  input logic latch,
  input logic oe_n
);

  // read by the testbench for its closing summary
  int failure_count = 0;

  // a latch pulse while the panel is lit would tear the image
  latch_while_dark: assert property (@(posedge clk) disable iff (reset) !(latch && !oe_n))
    else begin
      failure_count++;
      $error("latch high while output enabled");
    end

  // serial clock only toggles in the shift phase, where latch is low and output dark
  sclk_in_shift: assert property (@(posedge clk) disable iff (reset) sclk |-> (oe_n && !latch))
    else begin
      failure_count++;
      $error("sclk high outside the shift phase");
    end

  // address must not move while a line is shown
  row_held_while_lit: assert property (@(posedge clk) disable iff (reset) !oe_n |-> $stable(row))
    else begin
      failure_count++;
      $error("row changed while output enabled");
    end

endmodule

bind line_scanner hub75_assertions i_protocol_checks (
  .clk(clk),
  .reset(reset),
  .row(row),
  .sclk(sclk),
  .latch(latch),
  .oe_n(oe_n)
);

`default_nettype wire

// ==== bench/hub75_tb.sv ====
// ----------------------------
// testbench for the hub75 driver
// loads an image, follows the panel signals and checks data and timing
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module hub75_tb;

  import hub75_pkg::*;

  localparam int div_ratio = 4;
  localparam int table_size = 10;
  // 128 shift ticks, latch, show and one advance tick per line
  localparam int line_ticks = 2 * panel_columns + latch_ticks + show_ticks + 1;
  localparam int lines_to_check = 3 * scan_lines;
  localparam int cycle_limit = line_ticks * div_ratio * scan_lines * 3 + 8192;

  logic clk;
  logic reset;
  logic pixel_wr_en;
  pixel_write_t pixel_wr;
  hub75_port_t panel;

  // expected image, [half][row][column]
  rgb_t model [2][scan_lines][panel_columns];

  // overwrite table, last entry goes in during the second frame
  string entry_name [table_size];
  pixel_write_t entry_write [table_size];

  int value_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;
  int lines_checked = 0;
  int wraps = 0;
  int line_clks = 0;
  int sclk_rises = 0;
  int latch_clks = 0;
  int dark_clks = 0;
  bit loading_done = 0;
  bit checking = 0;
  bit late_written = 0;
  bit late_seen = 0;
  hub75_port_t prev;

  hub75_driver #(
    .div_ratio(div_ratio)
  ) i_dut (
    .clk(clk),
    .reset(reset),
    .pixel_wr_en(pixel_wr_en),
    .pixel_wr(pixel_wr),
    .panel(panel)
  );

  always #20 clk = ~clk;

  task automatic check_value(string name, int expected, int actual);
    assert (expected == actual) else begin
      value_errors++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_true(string failure, bit cond);
    assert (cond) else begin
      other_errors++;
      $display("ERROR %s", failure);
    end
  endtask

  function automatic pixel_write_t make_write(int half, int row, int column, int color);
    pixel_write_t w;
    w.half = half[0];
    w.row = row_t'(row);
    w.column = column_t'(column);
    w.color = rgb_t'(color[2:0]);
    return w;
  endfunction

  // test name for one pixel check
  // a pixel that a written table entry covers goes by the entry name
  function automatic string pixel_name(int half, int row, int column);
    string name;
    name = $sformatf("%s pixel row %0d column %0d", half ? "bottom" : "top", row, column);
    for (int i = 0; i < table_size; i++) begin
      if (entry_write[i].half == half && entry_write[i].row == row
          && entry_write[i].column == column && (i < table_size - 1 || late_written)) begin
        name = entry_name[i];
      end
    end
    return name;
  endfunction

  // drive one write strobe and record it in the model
  task automatic write_pixel(pixel_write_t w);
    @(posedge clk);
    #2;
    pixel_wr_en = 1'b1;
    pixel_wr = w;
    model[w.half][w.row][w.column] = w.color;
  endtask

  task automatic end_writes();
    @(posedge clk);
    #2;
    pixel_wr_en = 1'b0;
  endtask

  task automatic build_table();
    entry_name[0] = "top corner first";
    entry_write[0] = make_write(0, 0, 0, 7);
    entry_name[1] = "top corner last column";
    entry_write[1] = make_write(0, 0, 63, 1);
    entry_name[2] = "top corner last row";
    entry_write[2] = make_write(0, 31, 0, 2);
    entry_name[3] = "bottom corner last";
    entry_write[3] = make_write(1, 31, 63, 4);
    entry_name[4] = "bottom white";
    entry_write[4] = make_write(1, 5, 20, 7);
    entry_name[5] = "top black";
    entry_write[5] = make_write(0, 12, 40, 0);
    entry_name[6] = "top random";
    entry_write[6] = make_write(0, 7, 9, $urandom % 8);
    entry_name[7] = "bottom random";
    entry_write[7] = make_write(1, 18, 33, $urandom % 8);
    entry_name[8] = "top random late column";
    entry_write[8] = make_write(0, 25, 50, $urandom % 8);
    // background here is 0, so the change is visible
    entry_name[9] = "late write";
    entry_write[9] = make_write(1, 10, 10, 5);
  endtask

  // panel follower, samples at the falling edge where outputs are settled
  always @(negedge clk) begin
    hub75_port_t cur;
    int col;
    cur = panel;
    line_clks++;
    if (!reset) begin
      // address step, one per line
      if (cur.addr != prev.addr) begin
        if (checking) begin
          check_value("addr step", (prev.addr + 1) % scan_lines, cur.addr);
          check_true("addr changed while output was enabled", cur.oe_n && prev.oe_n);
          check_value("line length in clocks", line_ticks * div_ratio, line_clks);
          if (prev.addr == scan_lines - 1) begin
            wraps++;
          end
          lines_checked++;
        end else if (loading_done) begin
          checking = 1'b1;
        end
        line_clks = 0;
        sclk_rises = 0;
      end
      // pixel data at each rising serial clock
      if (!prev.sclk && cur.sclk) begin
        sclk_rises++;
        col = sclk_rises - 1;
        if (checking && col < panel_columns) begin
          check_value(pixel_name(0, cur.addr, col),
                      int'(model[0][cur.addr][col]), int'(cur.rgb_top));
          check_value(pixel_name(1, cur.addr, col),
                      int'(model[1][cur.addr][col]), int'(cur.rgb_bottom));
          if (late_written && cur.addr == entry_write[9].row && col == entry_write[9].column
              && cur.rgb_bottom == entry_write[9].color) begin
            late_seen = 1'b1;
          end
        end
      end
      // latch pulse width and edge count per line
      if (cur.latch) begin
        latch_clks = prev.latch ? latch_clks + 1 : 1;
      end
      if (checking && !prev.latch && cur.latch) begin
        check_value("sclk rises per line", panel_columns, sclk_rises);
      end
      if (checking && prev.latch && !cur.latch) begin
        check_value("latch width in clocks", div_ratio, latch_clks);
        check_true("latch fell without oe_n falling", prev.oe_n && !cur.oe_n);
      end
      // display window
      if (!cur.oe_n) begin
        dark_clks = !prev.oe_n ? dark_clks + 1 : 1;
      end
      if (checking && prev.oe_n && !cur.oe_n) begin
        check_true("oe_n fell on a clock where latch did not fall", prev.latch && !cur.latch);
      end
      if (checking && !prev.oe_n && cur.oe_n) begin
        check_value("show time in clocks", show_ticks * div_ratio, dark_clks);
      end
    end
    prev = cur;
  end

  // run limit, three frames plus margin for reset and loading
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, scan did not reach the end of the run", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int seed_dummy;
    int assert_errors;
    seed_dummy = $urandom(32'h8da6d255);
    clk = 1'b0;
    reset = 1'b1;
    pixel_wr_en = 1'b0;
    pixel_wr = '0;
    prev = '0;
    build_table();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    // idle outputs until the first tick
    repeat (div_ratio) begin
      @(negedge clk);
      check_value("idle oe_n", 1, panel.oe_n);
      check_value("idle latch", 0, panel.latch);
      check_value("idle sclk", 0, panel.sclk);
      check_value("idle addr", 0, panel.addr);
    end
    // background image then the table overwrites
    for (int h = 0; h < 2; h++) begin
      for (int r = 0; r < scan_lines; r++) begin
        for (int c = 0; c < panel_columns; c++) begin
          write_pixel(make_write(h, r, c, (r + c + 4 * h) % 8));
        end
      end
    end
    for (int i = 0; i < table_size - 1; i++) begin
      write_pixel(entry_write[i]);
    end
    end_writes();
    loading_done = 1'b1;
    // second frame, write while the panel is lit so no data edge is near
    wait (lines_checked >= scan_lines + 8);
    wait (panel.oe_n == 1'b0);
    write_pixel(entry_write[9]);
    end_writes();
    late_written = 1'b1;
    wait (lines_checked >= lines_to_check);
    @(negedge clk);
    check_true("addr never wrapped from 31 to 0", wraps >= 1);
    check_true({entry_name[9], " was never seen on the panel"}, late_seen);
    assert_errors = i_dut.i_line_scanner.i_protocol_checks.failure_count;
    $display("errors: value %0d, other %0d, assertion %0d",
             value_errors, other_errors, assert_errors);
    if (value_errors + other_errors + assert_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/hub75_pkg.sv
hdl/scan_tick.sv
hdl/frame_buffer.sv
hdl/line_scanner.sv
hdl/hub75_driver.sv
bench/hub75_assertions.sv
bench/hub75_tb.sv
